/* fnd_pkg.sv */
`default_nettype none

package fnd_pkg;

    ////////////////////////////////////////////////////////////
    // display geometry
    ////////////////////////////////////////////////////////////

    localparam int NUM_DIGITS    = 4;
    localparam int DIGIT_W       = 4;                     // one hex or bcd digit
    localparam int VALUE_W       = NUM_DIGITS * DIGIT_W;  // whole count
    localparam int SEG_W         = 8;                     // a..g plus dp

    // scan divider width, one tick every 2**SCAN_DIV_BITS cycles
    // a board build raises this to slow the refresh down
    localparam int SCAN_DIV_BITS = 4;

    ////////////////////////////////////////////////////////////
    // data types
    ////////////////////////////////////////////////////////////

    typedef logic [DIGIT_W-1:0]    digit_t;
    typedef logic [VALUE_W-1:0]    value_t;   // digit 0 in the low bits
    typedef logic [SEG_W-1:0]      seg_t;     // a b c d e f g dp, msb first, active low
    typedef logic [NUM_DIGITS-1:0] com_t;     // one low bit enables a digit

    // digit limits for the two counting modes
    localparam digit_t BCD_MAX = 4'd9;
    localparam digit_t HEX_MAX = 4'hf;

    // rightmost digit active after reset
    localparam com_t   COM_FIRST = 4'b1110;

    ////////////////////////////////////////////////////////////
    // opcodes and link states
    ////////////////////////////////////////////////////////////

    // one step of the counter, non-hold for a single cycle
    typedef enum logic [1:0] {
        OP_HOLD = 2'b00,
        OP_UP   = 2'b01,
        OP_DOWN = 2'b10
    } count_op_t;

    // four-phase req/ack, used on both sides of the link
    //   idle    : no transfer in flight
    //   req     : sender has req up / receiver has ack up
    //   release : waiting for the other side to drop its line
    typedef enum logic [1:0] {
        LINK_IDLE    = 2'b00,
        LINK_REQ     = 2'b01,
        LINK_RELEASE = 2'b10
    } link_state_t;

endpackage

`default_nettype wire

/* count_link_if.sv */
`default_nettype none

// count snapshot from the counter to the display latch
interface count_link_if
    import fnd_pkg::*;
();

    logic   req;      // value and wrapped stable while high
    logic   ack;
    value_t value;
    logic   wrapped;  // last step rolled over

    modport sender (
        output req, value, wrapped,
        input  ack
    );

    modport receiver (
        input  req, value, wrapped,
        output ack
    );

endinterface

`default_nettype wire

/* step_edge_detector.sv */
`default_nettype none

module step_edge_detector
    import fnd_pkg::*;
(
    input  logic      clk,
    input  logic      reset_p,
    input  logic      step,
    input  logic      down_up,   // 1 counts down
    output count_op_t op
);

    logic ff_cur;   // step sampled this edge
    logic ff_old;   // step sampled one edge earlier
    logic ff_dir;   // direction taken with ff_cur

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            ff_cur <= 1'b0;
            ff_old <= 1'b0;
            ff_dir <= 1'b0;
        end else begin
            ff_cur <= step;
            ff_old <= ff_cur;
            ff_dir <= down_up;
        end
    end

    // low then high on step gives one op cycle
    always_comb begin
        if ({ff_cur, ff_old} == 2'b10) begin
            op = ff_dir ? OP_DOWN : OP_UP;
        end else begin
            op = OP_HOLD;
        end
    end

endmodule

`default_nettype wire

/* digit_counter.sv */
`default_nettype none

module digit_counter
    import fnd_pkg::*;
(
    input  logic         clk,
    input  logic         reset_p,
    input  logic         bcd_mode,  // held steady outside reset
    input  count_op_t    op,
    count_link_if.sender link
);

    value_t      count;
    value_t      count_next;
    logic        wrapped;
    logic        step_now;
    logic        carry;      // carry or borrow rippling up the digits
    digit_t      digit_max;
    digit_t      cur;
    logic        pending;    // count changed since last snapshot
    link_state_t tx_state;
    value_t      tx_value;
    logic        tx_wrapped;

    ////////////////////////////////////////////////////////////
    // up/down digit chain
    ////////////////////////////////////////////////////////////

    assign step_now  = (op != OP_HOLD);
    assign digit_max = bcd_mode ? BCD_MAX : HEX_MAX;

    // each digit moves only when everything below it wrapped
    always_comb begin
        count_next = count;
        carry      = step_now;
        cur        = '0;
        for (int i = 0; i < NUM_DIGITS; i++) begin
            cur = count[i*DIGIT_W +: DIGIT_W];
            if (carry) begin
                if (op == OP_UP) begin
                    if (cur >= digit_max) begin
                        count_next[i*DIGIT_W +: DIGIT_W] = '0;  // carry on
                    end else begin
                        count_next[i*DIGIT_W +: DIGIT_W] = cur + digit_t'(1);
                        carry = 1'b0;
                    end
                end else begin
                    if (cur == '0) begin
                        count_next[i*DIGIT_W +: DIGIT_W] = digit_max;  // borrow on
                    end else begin
                        count_next[i*DIGIT_W +: DIGIT_W] = cur - digit_t'(1);
                        carry = 1'b0;
                    end
                end
            end
        end
    end

    // carry still set after digit 3 means the whole count rolled over
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            count   <= '0;
            wrapped <= 1'b0;
        end else if (step_now) begin
            count   <= count_next;
            wrapped <= carry;
        end
    end

    ////////////////////////////////////////////////////////////
    // link sender
    ////////////////////////////////////////////////////////////

    // a step during a transfer keeps pending up for one more round
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            pending  <= 1'b0;
            tx_state <= LINK_IDLE;
        end else begin
            pending <= step_now | (pending & (tx_state != LINK_IDLE));
            case (tx_state)
                LINK_IDLE: begin
                    if (pending) tx_state <= LINK_REQ;
                end
                LINK_REQ: begin
                    if (link.ack) tx_state <= LINK_RELEASE;
                end
                LINK_RELEASE: begin
                    if (!link.ack) tx_state <= LINK_IDLE;   // four phases done
                end
                default: tx_state <= LINK_IDLE;
            endcase
        end
    end

    // snapshot taken on the edge that raises req
    always_ff @(posedge clk) begin
        if (tx_state == LINK_IDLE && pending) begin
            tx_value   <= count;
            tx_wrapped <= wrapped;
        end
    end

    assign link.req     = (tx_state == LINK_REQ);
    assign link.value   = tx_value;
    assign link.wrapped = tx_wrapped;

endmodule

`default_nettype wire

/* display_scanner.sv */
`default_nettype none

module display_scanner
    import fnd_pkg::*;
(
    input  logic           clk,
    input  logic           reset_p,
    count_link_if.receiver link,
    output digit_t         digit,
    output logic           dp_on,
    output com_t           com
);

    link_state_t               rx_state;
    value_t                    disp_value;    // display latch
    logic                      disp_wrapped;
    logic [SCAN_DIV_BITS-1:0]  scan_cnt;
    logic                      scan_tick;

    ////////////////////////////////////////////////////////////
    // link receiver and display latch
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            rx_state     <= LINK_IDLE;
            disp_value   <= '0;
            disp_wrapped <= 1'b0;
        end else begin
            case (rx_state)
                LINK_IDLE: begin
                    if (link.req) begin           // ack is low here
                        disp_value   <= link.value;
                        disp_wrapped <= link.wrapped;
                        rx_state     <= LINK_REQ;
                    end
                end
                LINK_REQ: begin
                    if (!link.req) rx_state <= LINK_RELEASE;
                end
                LINK_RELEASE: begin
                    rx_state <= LINK_IDLE;        // ack already low
                end
                default: rx_state <= LINK_IDLE;
            endcase
        end
    end

    assign link.ack = (rx_state == LINK_REQ);

    ////////////////////////////////////////////////////////////
    // scan tick and common ring
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            scan_cnt <= '0;
        end else begin
            scan_cnt <= scan_cnt + 1'b1;          // free running
        end
    end

    assign scan_tick = &scan_cnt;

    // right to left, then back to the rightmost digit
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            com <= COM_FIRST;
        end else if (scan_tick) begin
            case (com)
                4'b1110: com <= 4'b1101;
                4'b1101: com <= 4'b1011;
                4'b1011: com <= 4'b0111;
                4'b0111: com <= 4'b1110;
                default: com <= COM_FIRST;        // recover from a bad pattern
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // digit select
    ////////////////////////////////////////////////////////////

    always_comb begin
        digit = '0;
        for (int i = 0; i < NUM_DIGITS; i++) begin
            if (!com[i]) digit = disp_value[i*DIGIT_W +: DIGIT_W];
        end
    end

    // wrap marker on the rightmost dp only
    assign dp_on = disp_wrapped & ~com[0];

endmodule

`default_nettype wire

/* seven_seg_decoder.sv */
`default_nettype none

module seven_seg_decoder
    import fnd_pkg::*;
(
    input  digit_t digit,
    input  logic   dp_on,
    output seg_t   seg_7
);

    logic [SEG_W-2:0] font;  // a..g glyph

    always_comb begin
        case (digit)
                              // abcdefg
            4'h0: font = 7'b0000001;
            4'h1: font = 7'b1001111;
            4'h2: font = 7'b0010010;
            4'h3: font = 7'b0000110;
            4'h4: font = 7'b1001100;
            4'h5: font = 7'b0100100;
            4'h6: font = 7'b0100000;
            4'h7: font = 7'b0001101;
            4'h8: font = 7'b0000000;
            4'h9: font = 7'b0001100;
            4'ha: font = 7'b0001000;  // A
            4'hb: font = 7'b1100000;  // b
            4'hc: font = 7'b0110001;  // C
            4'hd: font = 7'b1000010;  // d
            4'he: font = 7'b0110000;  // E
            4'hf: font = 7'b0111000;  // F
            default: font = '1;
        endcase
    end

    // dp lights when pulled low
    assign seg_7 = {font, ~dp_on};

endmodule

`default_nettype wire

/* fnd_counter_top.sv */
`default_nettype none

module fnd_counter_top
    import fnd_pkg::*;
(
    input  logic clk,
    input  logic reset_p,
    input  logic step,
    input  logic down_up,   // 1 counts down
    input  logic bcd_mode,  // change only under reset
    output seg_t seg_7,
    output com_t com
);

    count_op_t op;
    digit_t    digit;
    logic      dp_on;

    count_link_if link ();

    step_edge_detector u_edge (
        .clk     (clk),
        .reset_p (reset_p),
        .step    (step),
        .down_up (down_up),
        .op      (op)
    );

    digit_counter u_counter (
        .clk      (clk),
        .reset_p  (reset_p),
        .bcd_mode (bcd_mode),
        .op       (op),
        .link     (link.sender)
    );

    display_scanner u_scanner (
        .clk     (clk),
        .reset_p (reset_p),
        .link    (link.receiver),
        .digit   (digit),
        .dp_on   (dp_on),
        .com     (com)
    );

    seven_seg_decoder u_decoder (
        .digit (digit),
        .dp_on (dp_on),
        .seg_7 (seg_7)
    );

endmodule

`default_nettype wire

/* tb_fnd_counter.sv */
`default_nettype none

module tb_fnd_counter
    import fnd_pkg::*;
();

    localparam int NUM_ROWS      = 11;
    localparam int CLK_HALF      = 10;
    localparam int DRIVE_DLY     = 2;   // after the rising edge
    localparam int RESET_CYCLES  = 4;
    localparam int SETTLE_CYCLES = 20;

    logic clk;
    logic reset_p;
    logic step;
    logic down_up;
    logic bcd_mode;
    seg_t seg_7;
    com_t com;

    // stimulus table, one entry per row
    string  row_name  [NUM_ROWS];
    logic   row_reset [NUM_ROWS];
    logic   row_bcd   [NUM_ROWS];
    logic   row_down  [NUM_ROWS];
    int     row_steps [NUM_ROWS];
    logic   row_burst [NUM_ROWS];
    value_t row_value [NUM_ROWS];
    logic   row_wrap  [NUM_ROWS];
    int     row_count = 0;

    int unsigned lcg_state;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    fnd_counter_top uut (
        .clk      (clk),
        .reset_p  (reset_p),
        .step     (step),
        .down_up  (down_up),
        .bcd_mode (bcd_mode),
        .seg_7    (seg_7),
        .com      (com)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout: run did not finish within %0d clock cycles", cycle_limit);
            $display("TEST RESULT: FAIL");
            $fatal(1, "simulation stopped on timeout");
        end
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    function automatic int unsigned next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // active-low font, a..g then dp
    function automatic seg_t expected_glyph(input digit_t d, input logic dp_lit);
        logic [6:0] abcdefg;
        case (d)
            4'h0: abcdefg = 7'b0000001;
            4'h1: abcdefg = 7'b1001111;
            4'h2: abcdefg = 7'b0010010;
            4'h3: abcdefg = 7'b0000110;
            4'h4: abcdefg = 7'b1001100;
            4'h5: abcdefg = 7'b0100100;
            4'h6: abcdefg = 7'b0100000;
            4'h7: abcdefg = 7'b0001101;
            4'h8: abcdefg = 7'b0000000;
            4'h9: abcdefg = 7'b0001100;
            4'ha: abcdefg = 7'b0001000;
            4'hb: abcdefg = 7'b1100000;
            4'hc: abcdefg = 7'b0110001;
            4'hd: abcdefg = 7'b1000010;
            4'he: abcdefg = 7'b0110000;
            4'hf: abcdefg = 7'b0111000;
            default: abcdefg = 7'b1111111;
        endcase
        return {abcdefg, ~dp_lit};
    endfunction

    task automatic check(input string name, input logic [15:0] expected,
                         input logic [15:0] actual);
        if (expected !== actual) begin
            $display("** Error [%s]: expected %h, actual %h", name, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic add_row(input string name, input logic rst, input logic bcd,
                           input logic down, input int steps, input logic burst,
                           input value_t value, input logic wrap);
        row_name[row_count]  = name;
        row_reset[row_count] = rst;
        row_bcd[row_count]   = bcd;
        row_down[row_count]  = down;
        row_steps[row_count] = steps;
        row_burst[row_count] = burst;
        row_value[row_count] = value;
        row_wrap[row_count]  = wrap;
        row_count++;
    endtask

    task automatic load_table();
        //       name               rst   bcd   down  n    burst value     wrap
        add_row("reset_state",     1'b1, 1'b0, 1'b0, 0,   1'b0, 16'h0000, 1'b0);
        add_row("hex_up_17",       1'b1, 1'b0, 1'b0, 17,  1'b0, 16'h0011, 1'b0);
        add_row("hex_up_255",      1'b0, 1'b0, 1'b0, 255, 1'b0, 16'h0110, 1'b0);
        add_row("hex_down_wrap",   1'b1, 1'b0, 1'b1, 1,   1'b0, 16'hffff, 1'b1);
        add_row("hex_up_wrap",     1'b0, 1'b0, 1'b0, 1,   1'b0, 16'h0000, 1'b1);
        add_row("hex_up_one",      1'b0, 1'b0, 1'b0, 1,   1'b0, 16'h0001, 1'b0);
        add_row("bcd_up_10",       1'b1, 1'b1, 1'b0, 10,  1'b0, 16'h0010, 1'b0);
        add_row("bcd_up_90",       1'b0, 1'b1, 1'b0, 90,  1'b0, 16'h0100, 1'b0);
        add_row("bcd_down_wrap",   1'b1, 1'b1, 1'b1, 1,   1'b0, 16'h9999, 1'b1);
        add_row("bcd_up_wrap",     1'b0, 1'b1, 1'b0, 1,   1'b0, 16'h0000, 1'b1);
        add_row("burst_up_9",      1'b1, 1'b0, 1'b0, 9,   1'b1, 16'h0009, 1'b0);
    endtask

    task automatic wait_drive_slot();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    // reset with the new mode, then look at the idle display
    task automatic apply_reset(input string name, input logic bcd);
        reset_p  = 1'b1;
        step     = 1'b0;
        down_up  = 1'b0;
        bcd_mode = bcd;
        repeat (RESET_CYCLES) wait_drive_slot();
        reset_p = 1'b0;
        @(negedge clk);
        check({name, " com after reset"}, 16'(COM_FIRST), 16'(com));
        check({name, " seg after reset"}, 16'(expected_glyph(4'h0, 1'b0)), 16'(seg_7));
        wait_drive_slot();
    endtask

    task automatic send_steps(input int n, input logic burst);
        int gap;
        int high;
        for (int i = 0; i < n; i++) begin
            high = burst ? 2 : 3;
            gap  = burst ? 2 + int'((next_random() >> 16) % 4) : 3;
            step = 1'b1;
            repeat (high) wait_drive_slot();
            step = 1'b0;
            repeat (gap) wait_drive_slot();
        end
    endtask

    // one full scan from the rightmost digit, sampled on the falling edge
    task automatic read_display(input int row);
        string  name;
        value_t value;
        logic   wrap;
        com_t   next_com;
        seg_t   want_seg;
        name  = row_name[row];
        value = row_value[row];
        wrap  = row_wrap[row];
        repeat (SETTLE_CYCLES) @(posedge clk);
        @(negedge clk);
        while (com !== COM_FIRST) @(negedge clk);
        for (int k = 0; k < NUM_DIGITS; k++) begin
            want_seg = expected_glyph(value[k*DIGIT_W +: DIGIT_W], wrap && (k == 0));
            check($sformatf("%s digit %0d", name, k), 16'(want_seg), 16'(seg_7));
            while (com === ~(com_t'(1) << k)) @(negedge clk);
            next_com = (k == NUM_DIGITS - 1) ? COM_FIRST : ~(com_t'(1) << (k + 1));
            check({name, " one low com bit"}, 16'd1, 16'($countones(~com)));
            check({name, " scan order"}, 16'(next_com), 16'(com));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int total;
        reset_p   = 1'b1;
        step      = 1'b0;
        down_up   = 1'b0;
        bcd_mode  = 1'b0;
        lcg_state = 32'd72771;
        total     = 0;
        load_table();
        for (int r = 0; r < row_count; r++) begin
            total += row_steps[r];
        end
        cycle_limit = total * 12 + row_count * 200 + 100;

        for (int r = 0; r < row_count; r++) begin
            wait_drive_slot();
            if (row_reset[r]) apply_reset(row_name[r], row_bcd[r]);
            down_up = row_down[r];   // set before the step rises
            send_steps(row_steps[r], row_burst[r]);
            read_display(r);
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
fnd_pkg.sv
count_link_if.sv
step_edge_detector.sv
digit_counter.sv
display_scanner.sv
seven_seg_decoder.sv
fnd_counter_top.sv
tb_fnd_counter.sv

/* run_sim.sh */
#!/bin/bash
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f list.f --top-module tb_fnd_counter -o Vtb_fnd_counter

# the simulator stops with an error status on a failure, the log decides
./obj_dir/Vtb_fnd_counter > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0
